//--- logic/dcache_pkg.sv
package dcache_pkg;

  localparam int XLEN   = 64;   // core data word
  localparam int ADDR_W = 32;   // byte address
  localparam int LINE_W = 128;  // one sram bank word
  localparam int BEATS  = 8;    // 64-bit beats per 64-byte line

  // one bank word seen either as two doublewords or as sixteen bytes.
  // store data is placed by dw, the write mask is built by b
  typedef union packed {
    logic [1:0][XLEN-1:0] dw;
    logic [15:0][7:0]     b;
  } dc_line_u;

  typedef enum logic [2:0] {
    IDLE,         // wait for core request
    LOOKUP,       // tag compare, sram data valid
    HIT_DONE,     // result registered, raise ack
    WB_READ,      // latch victim beat from the banks
    WB_BEAT,      // write beat handshake to memory
    ALLOC_BEAT,   // refill beat handshake from memory
    REFILL_DONE,  // re-read bank, merge store, update tag
    ACK_LOW       // wait for core to drop req
  } dc_state_e;

endpackage

//--- logic/sram_1p_bw.sv
`timescale 1ns/10ps

module sram_1p_bw #(
  parameter int DEPTH_LOG2 = 6
) (
  input  logic                          clk,
  input  logic [DEPTH_LOG2-1:0]         addr_i,
  input  logic                          wen_i,
  input  logic [dcache_pkg::LINE_W-1:0] bwen_i,
  input  logic [dcache_pkg::LINE_W-1:0] wdata_i,
  output logic [dcache_pkg::LINE_W-1:0] rdata_o
);

  import dcache_pkg::*;

  logic [LINE_W-1:0] mem [2**DEPTH_LOG2];

  // read-first so a write shows up on the next access
  always_ff @(posedge clk) begin
    if (wen_i) begin
      mem[addr_i] <= (mem[addr_i] & ~bwen_i) | (wdata_i & bwen_i); // per bit mask
    end
    rdata_o <= mem[addr_i];
  end

endmodule

//--- logic/dcache_data.sv
`timescale 1ns/10ps

module dcache_data #(
  parameter int IDX_LEN = 6,
  parameter int BLK_LEN = 6
) (
  input  logic                        clk,
  input  logic [IDX_LEN-1:0]          index_i,
  input  logic [BLK_LEN-1:0]          blk_addr_i,
  input  logic [dcache_pkg::XLEN-1:0] line_wdata_i,
  input  logic [7:0]                  wstrb_i,
  input  logic [2:0]                  burst_count_i,
  input  logic                        allocate_valid_i,
  input  logic                        writeback_valid_i,
  input  logic                        wen_i,
  output logic [dcache_pkg::XLEN-1:0] writeback_data_o,
  output logic [dcache_pkg::XLEN-1:0] rdata_o
);

  import dcache_pkg::*;

  logic [1:0] bank_sel;   // which 128-bit bank
  logic       dw_sel;     // which half of the bank word
  logic [3:0] bank_wen;
  dc_line_u   wline;
  dc_line_u   wmask;
  dc_line_u   bank_q [4];

  // refill beats walk the banks in order and core accesses use the offset
  assign bank_sel = allocate_valid_i ? burst_count_i[2:1] : blk_addr_i[5:4];
  assign dw_sel   = allocate_valid_i ? burst_count_i[0] : blk_addr_i[3];

  always_comb begin
    wline            = '0;
    wline.dw[dw_sel] = line_wdata_i;
    wmask            = '0;
    for (int i = 0; i < 8; i++) begin
      // whole doubleword on refill and strobed bytes on a store
      wmask.b[{dw_sel, 3'(i)}] = {8{allocate_valid_i | wstrb_i[i]}};
    end
  end

  for (genvar k = 0; k < 4; k++) begin : g_bank
    // no bank is written while the victim line is read out
    assign bank_wen[k] = wen_i & ~writeback_valid_i & (bank_sel == 2'(k));

    sram_1p_bw #(
      .DEPTH_LOG2(IDX_LEN)
    ) bank_inst (
      .clk     (clk),
      .addr_i  (index_i),
      .wen_i   (bank_wen[k]),
      .bwen_i  (wmask),
      .wdata_i (wline),
      .rdata_o (bank_q[k])
    );
  end

  // hit read picks bank and doubleword from the block offset
  assign rdata_o = bank_q[blk_addr_i[5:4]].dw[blk_addr_i[3]];

  // writeback beat n is doubleword n of the line
  assign writeback_data_o = bank_q[burst_count_i[2:1]].dw[burst_count_i[0]];

endmodule

//--- logic/dcache_tag.sv
`timescale 1ns/10ps

module dcache_tag #(
  parameter int IDX_LEN = 6,
  parameter int BLK_LEN = 6,
  localparam int TAG_W = dcache_pkg::ADDR_W - IDX_LEN - BLK_LEN
) (
  input  logic               clk,
  input  logic               arst_n_i,
  input  logic [IDX_LEN-1:0] index_i,
  input  logic [TAG_W-1:0]   tag_i,
  input  logic               tag_wen_i,
  input  logic               set_dirty_i,
  input  logic               clr_dirty_i,
  output logic               hit_o,
  output logic               dirty_o,
  output logic [TAG_W-1:0]   victim_tag_o
);

  localparam int SETS = 2**IDX_LEN;

  logic [TAG_W-1:0] tag_mem [SETS];
  logic [SETS-1:0]  valid_q;
  logic [SETS-1:0]  dirty_q;

  // tags themselves are only trusted when valid
  always_ff @(posedge clk) begin
    if (tag_wen_i) begin
      tag_mem[index_i] <= tag_i;
    end
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else begin
      if (tag_wen_i) begin
        valid_q[index_i] <= 1'b1;
      end
      if (set_dirty_i) begin
        dirty_q[index_i] <= 1'b1;   // set wins over clear
      end else if (clr_dirty_i) begin
        dirty_q[index_i] <= 1'b0;
      end
    end
  end

  assign victim_tag_o = tag_mem[index_i];
  assign hit_o        = valid_q[index_i] && (victim_tag_o == tag_i);
  assign dirty_o      = dirty_q[index_i];

endmodule

//--- logic/dcache_ctrl.sv
`timescale 1ns/10ps

module dcache_ctrl #(
  parameter int IDX_LEN = 6,
  parameter int BLK_LEN = 6,
  localparam int TAG_W = dcache_pkg::ADDR_W - IDX_LEN - BLK_LEN
) (
  input  logic                          clk,
  input  logic                          arst_n_i,
  // core side
  input  logic                          req_i,
  input  logic [dcache_pkg::ADDR_W-1:0] addr_i,
  input  logic                          wen_i,
  input  logic [dcache_pkg::XLEN-1:0]   wdata_i,
  input  logic [7:0]                    wstrb_i,
  output logic                          ack_o,
  output logic [dcache_pkg::XLEN-1:0]   rdata_o,
  // memory side, one handshake per beat
  output logic                          mem_req_o,
  output logic                          mem_we_o,
  output logic [dcache_pkg::ADDR_W-1:0] mem_addr_o,
  output logic [dcache_pkg::XLEN-1:0]   mem_wdata_o,
  input  logic                          mem_ack_i,
  input  logic [dcache_pkg::XLEN-1:0]   mem_rdata_i,
  // data array
  output logic [IDX_LEN-1:0]            index_o,
  output logic [BLK_LEN-1:0]            blk_addr_o,
  output logic [2:0]                    burst_count_o,
  output logic                          allocate_valid_o,
  output logic                          writeback_valid_o,
  output logic                          data_wen_o,
  output logic [dcache_pkg::XLEN-1:0]   line_wdata_o,
  output logic [7:0]                    wstrb_o,
  input  logic [dcache_pkg::XLEN-1:0]   data_rdata_i,
  input  logic [dcache_pkg::XLEN-1:0]   writeback_data_i,
  // tag array
  output logic [TAG_W-1:0]              tag_o,
  output logic                          tag_wen_o,
  output logic                          set_dirty_o,
  output logic                          clr_dirty_o,
  input  logic                          hit_i,
  input  logic                          dirty_i,
  input  logic [TAG_W-1:0]              victim_tag_i
);

  import dcache_pkg::*;

  dc_state_e        state_q;
  logic [2:0]       cnt_q;        // beat number within the line
  logic             ack_q;
  logic             mem_req_q;
  logic [TAG_W-1:0] tag_q;
  logic [IDX_LEN-1:0] idx_q;
  logic [BLK_LEN-1:0] blk_q;
  logic             wen_q;
  logic [XLEN-1:0]  wdata_q;
  logic [7:0]       wstrb_q;
  logic [XLEN-1:0]  rdata_q;
  logic [XLEN-1:0]  mem_wdata_q;
  logic             in_wb;
  logic             in_alloc;
  logic             beat_take;
  logic             beat_done;
  logic             last_beat;
  logic             store_hit;
  logic [TAG_W-1:0] line_tag;

  assign in_wb     = (state_q == WB_READ) || (state_q == WB_BEAT);
  assign in_alloc  = state_q == ALLOC_BEAT;
  assign beat_take = mem_req_q & mem_ack_i;     // memory answered this beat
  assign beat_done = ~mem_req_q & ~mem_ack_i;   // back at rest
  assign last_beat = cnt_q == 3'(BEATS - 1);
  assign store_hit = (state_q == LOOKUP) & hit_i & wen_q;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q   <= IDLE;
      cnt_q     <= '0;
      ack_q     <= 1'b0;
      mem_req_q <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          if (req_i) begin
            state_q <= LOOKUP;
          end
        end
        LOOKUP: begin
          cnt_q <= '0;
          if (hit_i) begin
            state_q <= HIT_DONE;
          end else if (dirty_i) begin
            state_q <= WB_READ;   // old line goes out first
          end else begin
            state_q   <= ALLOC_BEAT;
            mem_req_q <= 1'b1;
          end
        end
        HIT_DONE: begin
          ack_q   <= 1'b1;
          state_q <= ACK_LOW;
        end
        WB_READ: begin
          mem_req_q <= 1'b1;
          state_q   <= WB_BEAT;
        end
        WB_BEAT: begin
          if (beat_take) begin
            mem_req_q <= 1'b0;
          end else if (beat_done) begin
            cnt_q <= cnt_q + 3'd1;   // wraps to 0 for the refill
            if (last_beat) begin
              state_q   <= ALLOC_BEAT;
              mem_req_q <= 1'b1;
            end else begin
              state_q <= WB_READ;
            end
          end
        end
        ALLOC_BEAT: begin
          if (beat_take) begin
            mem_req_q <= 1'b0;
          end else if (beat_done) begin
            if (last_beat) begin
              state_q <= REFILL_DONE;
            end else begin
              cnt_q     <= cnt_q + 3'd1;
              mem_req_q <= 1'b1;
            end
          end
        end
        REFILL_DONE: begin
          ack_q   <= 1'b1;
          state_q <= ACK_LOW;
        end
        ACK_LOW: begin
          if (!req_i) begin
            ack_q   <= 1'b0;
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == IDLE && req_i) begin
      {tag_q, idx_q, blk_q} <= addr_i;
      wen_q                 <= wen_i;
      wdata_q               <= wdata_i;
      wstrb_q               <= wstrb_i;
    end
    // refill case reads the bank once more after the last beat landed
    if (state_q == LOOKUP || state_q == REFILL_DONE) begin
      rdata_q <= data_rdata_i;
    end
    if (state_q == WB_READ) begin
      mem_wdata_q <= writeback_data_i;
    end
  end

  // sram sees the incoming set while idle so data is ready in LOOKUP
  assign index_o           = (state_q == IDLE) ? addr_i[BLK_LEN +: IDX_LEN] : idx_q;
  assign blk_addr_o        = blk_q;
  assign burst_count_o     = cnt_q;
  assign allocate_valid_o  = in_alloc;
  assign writeback_valid_o = in_wb;
  assign data_wen_o        = store_hit | (in_alloc & beat_take) |
                             ((state_q == REFILL_DONE) & wen_q);
  assign line_wdata_o      = in_alloc ? mem_rdata_i : wdata_q;
  assign wstrb_o           = wstrb_q;

  assign tag_o       = tag_q;
  assign tag_wen_o   = state_q == REFILL_DONE;
  assign set_dirty_o = store_hit | (tag_wen_o & wen_q);  // store merged into line
  assign clr_dirty_o = tag_wen_o & ~wen_q;

  // victim tag for writeback, request tag for refill
  assign line_tag    = in_wb ? victim_tag_i : tag_q;
  assign mem_addr_o  = {line_tag, idx_q, {BLK_LEN{1'b0}}} | ADDR_W'({cnt_q, 3'b000});
  assign mem_we_o    = in_wb;
  assign mem_req_o   = mem_req_q;
  assign mem_wdata_o = mem_wdata_q;

  assign ack_o   = ack_q;
  assign rdata_o = rdata_q;

endmodule

//--- logic/dcache_top.sv
`timescale 1ns/10ps

module dcache_top #(
  parameter int IDX_LEN = 6,
  parameter int BLK_LEN = 6
) (
  input  logic                          clk,
  input  logic                          arst_n_i,
  input  logic                          req_i,
  input  logic [dcache_pkg::ADDR_W-1:0] addr_i,
  input  logic                          wen_i,
  input  logic [dcache_pkg::XLEN-1:0]   wdata_i,
  input  logic [7:0]                    wstrb_i,
  output logic                          ack_o,
  output logic [dcache_pkg::XLEN-1:0]   rdata_o,
  output logic                          mem_req_o,
  output logic                          mem_we_o,
  output logic [dcache_pkg::ADDR_W-1:0] mem_addr_o,
  output logic [dcache_pkg::XLEN-1:0]   mem_wdata_o,
  input  logic                          mem_ack_i,
  input  logic [dcache_pkg::XLEN-1:0]   mem_rdata_i
);

  import dcache_pkg::*;

  localparam int TAG_W = ADDR_W - IDX_LEN - BLK_LEN;

  // ctrl to data array
  logic [IDX_LEN-1:0] index;
  logic [BLK_LEN-1:0] blk_addr;
  logic [2:0]         burst_count;
  logic               allocate_valid;
  logic               writeback_valid;
  logic               data_wen;
  logic [XLEN-1:0]    line_wdata;
  logic [7:0]         line_wstrb;
  logic [XLEN-1:0]    data_rdata;
  logic [XLEN-1:0]    writeback_data;

  // ctrl to tag array
  logic [TAG_W-1:0]   req_tag;
  logic               tag_wen;
  logic               set_dirty;
  logic               clr_dirty;
  logic               hit;
  logic               dirty;
  logic [TAG_W-1:0]   victim_tag;

  dcache_ctrl #(
    .IDX_LEN(IDX_LEN),
    .BLK_LEN(BLK_LEN)
  ) ctrl_inst (
    .clk               (clk),
    .arst_n_i          (arst_n_i),
    .req_i             (req_i),
    .addr_i            (addr_i),
    .wen_i             (wen_i),
    .wdata_i           (wdata_i),
    .wstrb_i           (wstrb_i),
    .ack_o             (ack_o),
    .rdata_o           (rdata_o),
    .mem_req_o         (mem_req_o),
    .mem_we_o          (mem_we_o),
    .mem_addr_o        (mem_addr_o),
    .mem_wdata_o       (mem_wdata_o),
    .mem_ack_i         (mem_ack_i),
    .mem_rdata_i       (mem_rdata_i),
    .index_o           (index),
    .blk_addr_o        (blk_addr),
    .burst_count_o     (burst_count),
    .allocate_valid_o  (allocate_valid),
    .writeback_valid_o (writeback_valid),
    .data_wen_o        (data_wen),
    .line_wdata_o      (line_wdata),
    .wstrb_o           (line_wstrb),
    .data_rdata_i      (data_rdata),
    .writeback_data_i  (writeback_data),
    .tag_o             (req_tag),
    .tag_wen_o         (tag_wen),
    .set_dirty_o       (set_dirty),
    .clr_dirty_o       (clr_dirty),
    .hit_i             (hit),
    .dirty_i           (dirty),
    .victim_tag_i      (victim_tag)
  );

  dcache_tag #(
    .IDX_LEN(IDX_LEN),
    .BLK_LEN(BLK_LEN)
  ) tag_inst (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .index_i      (index),
    .tag_i        (req_tag),
    .tag_wen_i    (tag_wen),
    .set_dirty_i  (set_dirty),
    .clr_dirty_i  (clr_dirty),
    .hit_o        (hit),
    .dirty_o      (dirty),
    .victim_tag_o (victim_tag)
  );

  dcache_data #(
    .IDX_LEN(IDX_LEN),
    .BLK_LEN(BLK_LEN)
  ) data_inst (
    .clk               (clk),
    .index_i           (index),
    .blk_addr_i        (blk_addr),
    .line_wdata_i      (line_wdata),
    .wstrb_i           (line_wstrb),
    .burst_count_i     (burst_count),
    .allocate_valid_i  (allocate_valid),
    .writeback_valid_i (writeback_valid),
    .wen_i             (data_wen),
    .writeback_data_o  (writeback_data),
    .rdata_o           (data_rdata)
  );

endmodule

//--- testbench/dcache_mem_model.sv
`timescale 1ns/10ps

module dcache_mem_model #(
  parameter logic [63:0] PAT_MULT     = 64'h9e37_79b9_7f4a_7c15,
  parameter int          MAX_DELAY    = 3,
  parameter int          DROP_TIMEOUT = 20
) (
  input  logic                          clk,
  input  logic                          mem_req_i,
  input  logic                          mem_we_i,
  input  logic [dcache_pkg::ADDR_W-1:0] mem_addr_i,
  input  logic [dcache_pkg::XLEN-1:0]   mem_wdata_i,
  output logic                          mem_ack_o,
  output logic [dcache_pkg::XLEN-1:0]   mem_rdata_o,
  output logic                          stall_o
);

  import dcache_pkg::*;

  logic [XLEN-1:0] mem [logic [ADDR_W-1:0]];   // only words written back so far

  // untouched words hold address times a constant
  function automatic logic [XLEN-1:0] read_word(input logic [ADDR_W-1:0] a);
    if (mem.exists(a)) begin
      return mem[a];
    end
    return XLEN'(a) * PAT_MULT;
  endfunction

  initial begin
    logic [ADDR_W-1:0] addr;
    logic              we;
    logic [XLEN-1:0]   wdata;
    int                delay;
    int                n;
    mem_ack_o   = 1'b0;
    mem_rdata_o = '0;
    stall_o     = 1'b0;
    forever begin
      @(negedge clk);
      if (mem_req_i && !mem_ack_o) begin
        addr  = mem_addr_i;
        we    = mem_we_i;
        wdata = mem_wdata_i;
        delay = int'($urandom_range(MAX_DELAY, 0));   // 0..3 wait cycles
        repeat (delay) @(posedge clk);
        @(posedge clk);
        #2;
        if (we) begin
          mem[addr] = wdata;
        end else begin
          mem_rdata_o = read_word(addr);
        end
        mem_ack_o = 1'b1;
        n = 0;
        do begin
          @(negedge clk);
          n++;
        end while (mem_req_i && n < DROP_TIMEOUT);
        if (mem_req_i) begin
          $display("memory model: mem_req_o stayed high %0d cycles after mem_ack_i", n);
          stall_o = 1'b1;
        end
        @(posedge clk);
        #2;
        mem_ack_o = 1'b0;
      end
    end
  end

endmodule

//--- testbench/dcache_tb.sv
`timescale 1ns/10ps

module dcache_tb;

  import dcache_pkg::*;

  localparam int              IDX_LEN      = 6;
  localparam int              BLK_LEN      = 6;
  localparam int              TAG_W        = ADDR_W - IDX_LEN - BLK_LEN;
  localparam int              SETS         = 2**IDX_LEN;
  localparam logic [XLEN-1:0] PAT_MULT     = 64'h9e37_79b9_7f4a_7c15;
  localparam int              ACK_TIMEOUT  = 600;   // two slow bursts fit easily
  localparam int              DROP_TIMEOUT = 20;
  localparam int              RANDOM_OPS   = 400;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic              wen;
    logic [XLEN-1:0]   wdata;
    logic [7:0]        wstrb;
    logic [XLEN-1:0]   rdata;
    logic [15:0]       lat;     // edges from req sampled to ack seen
  } access_t;

  logic              clk;
  logic              arst_n;
  logic              req;
  logic [ADDR_W-1:0] addr;
  logic              wen;
  logic [XLEN-1:0]   wdata;
  logic [7:0]        wstrb;
  logic              ack;
  logic [XLEN-1:0]   rdata;
  logic              mem_req;
  logic              mem_we;
  logic [ADDR_W-1:0] mem_addr;
  logic [XLEN-1:0]   mem_wdata;
  logic              mem_ack;
  logic [XLEN-1:0]   mem_rdata;
  logic              mem_stall;

  logic [7:0]        shadow [logic [ADDR_W-1:0]];   // bytes stored by the core
  logic [TAG_W-1:0]  ref_tag   [SETS];
  logic              ref_valid [SETS];
  logic              ref_dirty [SETS];

  access_t           done_q [$];
  logic [ADDR_W-1:0] beat_addr_q [$];
  logic              beat_we_q [$];
  logic [XLEN-1:0]   beat_data_q [$];
  int                n_issued  = 0;
  int                n_checked = 0;

  dcache_top #(
    .IDX_LEN(IDX_LEN),
    .BLK_LEN(BLK_LEN)
  ) dcache_top_inst (
    .clk         (clk),
    .arst_n_i    (arst_n),
    .req_i       (req),
    .addr_i      (addr),
    .wen_i       (wen),
    .wdata_i     (wdata),
    .wstrb_i     (wstrb),
    .ack_o       (ack),
    .rdata_o     (rdata),
    .mem_req_o   (mem_req),
    .mem_we_o    (mem_we),
    .mem_addr_o  (mem_addr),
    .mem_wdata_o (mem_wdata),
    .mem_ack_i   (mem_ack),
    .mem_rdata_i (mem_rdata)
  );

  dcache_mem_model #(
    .PAT_MULT(PAT_MULT)
  ) mem_inst (
    .clk         (clk),
    .mem_req_i   (mem_req),
    .mem_we_i    (mem_we),
    .mem_addr_i  (mem_addr),
    .mem_wdata_i (mem_wdata),
    .mem_ack_o   (mem_ack),
    .mem_rdata_o (mem_rdata),
    .stall_o     (mem_stall)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic abort_run();
    $display("FAIL: see errors above");
    $fatal(1, "stopped at the first error");
  endtask

  always @(posedge mem_stall) begin
    abort_run();
  end

  function automatic logic [XLEN-1:0] pattern_word(input logic [ADDR_W-1:0] a);
    return XLEN'(a) * PAT_MULT;
  endfunction

  function automatic logic [XLEN-1:0] shadow_word(input logic [ADDR_W-1:0] a);
    logic [XLEN-1:0]   w;
    logic [ADDR_W-1:0] ba;
    int                i;
    w = pattern_word(a);
    for (i = 0; i < 8; i++) begin
      ba = a + ADDR_W'(i);
      if (shadow.exists(ba)) begin
        w[8*i +: 8] = shadow[ba];
      end
    end
    return w;
  endfunction

  // expected load value while stores update the shadow bytes under wstrb
  function automatic logic [XLEN-1:0] ref_access(input logic [ADDR_W-1:0] a, input logic we,
                                                 input logic [XLEN-1:0] d,
                                                 input logic [7:0] strb);
    logic [XLEN-1:0] old;
    int              i;
    old = shadow_word(a);
    if (we) begin
      for (i = 0; i < 8; i++) begin
        if (strb[i]) begin
          shadow[a + ADDR_W'(i)] = d[8*i +: 8];
        end
      end
    end
    return old;
  endfunction

  // hit prediction plus victim line for a dirty miss
  function automatic logic ref_lookup(input logic [ADDR_W-1:0] a, input logic we,
                                      output logic wb, output logic [ADDR_W-1:0] wb_base);
    logic [IDX_LEN-1:0] idx;
    logic [TAG_W-1:0]   tag;
    logic               hit;
    idx     = a[BLK_LEN +: IDX_LEN];
    tag     = a[ADDR_W-1 -: TAG_W];
    hit     = ref_valid[idx] && (ref_tag[idx] == tag);
    wb      = !hit && ref_valid[idx] && ref_dirty[idx];
    wb_base = {ref_tag[idx], idx, BLK_LEN'(0)};
    if (hit) begin
      ref_dirty[idx] = ref_dirty[idx] | we;
    end else begin
      ref_tag[idx]   = tag;
      ref_valid[idx] = 1'b1;
      ref_dirty[idx] = we;   // store miss merges after the fill
    end
    return hit;
  endfunction

  function automatic logic [ADDR_W-1:0] word_addr(input int tag, input int set, input int dw);
    return (ADDR_W'(tag) << (IDX_LEN + BLK_LEN)) | (ADDR_W'(set) << BLK_LEN) |
           (ADDR_W'(dw) << 3);
  endfunction

  // one four-phase core request where hold keeps req high after ack
  task automatic core_access(input logic [ADDR_W-1:0] acc_addr, input logic acc_wen,
                             input logic [XLEN-1:0] acc_data, input logic [7:0] acc_strb,
                             input int hold);
    access_t rec;
    int      n;
    @(posedge clk);
    #2;
    req   = 1'b1;
    addr  = acc_addr;
    wen   = acc_wen;
    wdata = acc_data;
    wstrb = acc_strb;
    n = 0;
    do begin
      @(posedge clk);
      n++;
      @(negedge clk);
    end while (!ack && n < ACK_TIMEOUT);
    if (!ack) begin
      $display("timeout: no ack_o within %0d cycles for address %08h", ACK_TIMEOUT, acc_addr);
      abort_run();
    end
    rec.addr  = acc_addr;
    rec.wen   = acc_wen;
    rec.wdata = acc_data;
    rec.wstrb = acc_strb;
    rec.rdata = rdata;
    rec.lat   = 16'(n - 1);   // first edge is the one that samples req
    done_q.push_back(rec);
    n_issued++;
    repeat (hold) begin
      @(negedge clk);
      assert (ack) else begin
        $display("Fail at %0t: ack_o dropped while req_i was still high", $time);
        abort_run();
      end
    end
    @(posedge clk);
    #2;
    req = 1'b0;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (ack && n < DROP_TIMEOUT);
    if (ack) begin
      $display("timeout: ack_o still high %0d cycles after req_i dropped", DROP_TIMEOUT);
      abort_run();
    end
  endtask

  // memory beat monitor with one entry per rising mem_req_o
  initial begin
    logic req_seen;
    req_seen = 1'b0;
    forever begin
      @(negedge clk);
      if (mem_req && !req_seen) begin
        beat_addr_q.push_back(mem_addr);
        beat_we_q.push_back(mem_we);
        beat_data_q.push_back(mem_wdata);
      end
      req_seen = mem_req;
    end
  end

  // compare each finished access with the reference functions
  initial begin
    access_t           acc;
    logic              hit_exp;
    logic              wb_exp;
    logic              we_exp;
    logic [ADDR_W-1:0] wb_base;
    logic [ADDR_W-1:0] fill_base;
    logic [ADDR_W-1:0] addr_exp;
    logic [ADDR_W-1:0] got_addr;
    logic              got_we;
    logic [XLEN-1:0]   got_data;
    logic [XLEN-1:0]   data_exp;
    int                nbeats;
    int                i;
    forever begin
      @(negedge clk);
      while (done_q.size() > 0) begin
        acc       = done_q.pop_front();
        hit_exp   = ref_lookup(acc.addr, acc.wen, wb_exp, wb_base);
        fill_base = {acc.addr[ADDR_W-1:BLK_LEN], BLK_LEN'(0)};
        nbeats    = hit_exp ? 0 : (wb_exp ? 2 * BEATS : BEATS);
        assert (beat_addr_q.size() == nbeats) else begin
          $display("Fail at %0t: access %08h made %0d memory beats, expected %0d",
                   $time, acc.addr, beat_addr_q.size(), nbeats);
          abort_run();
        end
        if (hit_exp) begin
          assert (acc.lat == 16'd2) else begin
            $display("Fail at %0t: hit on %08h acked after %0d cycles, expected 2",
                     $time, acc.addr, acc.lat);
            abort_run();
          end
        end
        for (i = 0; i < nbeats; i++) begin
          we_exp   = wb_exp && (i < BEATS);   // victim beats come first
          addr_exp = (we_exp ? wb_base : fill_base) + ADDR_W'(8 * (i % BEATS));
          got_addr = beat_addr_q.pop_front();
          got_we   = beat_we_q.pop_front();
          got_data = beat_data_q.pop_front();
          assert (got_we == we_exp && got_addr == addr_exp) else begin
            $display("Fail at %0t: beat %0d is we=%0b addr %08h, expected we=%0b addr %08h",
                     $time, i, got_we, got_addr, we_exp, addr_exp);
            abort_run();
          end
          if (we_exp) begin
            assert (got_data == shadow_word(addr_exp)) else begin
              $display("Fail at %0t: writeback of %08h carried %016h, expected %016h",
                       $time, addr_exp, got_data, shadow_word(addr_exp));
              abort_run();
            end
          end
        end
        data_exp = ref_access(acc.addr, acc.wen, acc.wdata, acc.wstrb);
        if (!acc.wen) begin
          assert (acc.rdata == data_exp) else begin
            $display("Fail at %0t: load %08h returned %016h, expected %016h",
                     $time, acc.addr, acc.rdata, data_exp);
            abort_run();
          end
        end
        n_checked++;
      end
    end
  end

  initial begin
    logic [ADDR_W-1:0] a;
    int                k;
    int                n;
    arst_n = 1'b0;
    req    = 1'b0;
    addr   = '0;
    wen    = 1'b0;
    wdata  = '0;
    wstrb  = '0;
    for (k = 0; k < SETS; k++) begin
      ref_tag[k]   = '0;
      ref_valid[k] = 1'b0;
      ref_dirty[k] = 1'b0;
    end
    void'($urandom(32'hadc));
    repeat (3) @(posedge clk);
    #2;
    arst_n = 1'b1;

    $display("cold load misses");
    for (k = 0; k < 4; k++) begin
      core_access(word_addr(1, k, 0), 1'b0, '0, '0, 0);
    end

    $display("repeated loads hit");
    for (k = 0; k < 4; k++) begin
      core_access(word_addr(1, k, 3), 1'b0, '0, '0, 0);
      core_access(word_addr(1, k, 7), 1'b0, '0, '0, 1);
    end

    $display("stores then loads on a resident line");
    for (k = 0; k < 8; k++) begin
      core_access(word_addr(1, 0, k), 1'b1, {$urandom, $urandom}, 8'($urandom_range(255, 0)), 0);
    end
    for (k = 0; k < 8; k++) begin
      core_access(word_addr(1, 0, k), 1'b0, '0, '0, 0);
    end

    $display("dirty eviction");
    core_access(word_addr(2, 0, 0), 1'b0, '0, '0, 0);

    $display("store miss, then eviction of the merged line");
    core_access(word_addr(3, 1, 5), 1'b1, {$urandom, $urandom}, 8'h5a, 0);
    core_access(word_addr(3, 1, 5), 1'b0, '0, '0, 0);
    core_access(word_addr(4, 1, 0), 1'b0, '0, '0, 0);

    $display("random mix of %0d accesses", RANDOM_OPS);
    for (k = 0; k < RANDOM_OPS; k++) begin
      a = word_addr(1 + int'($urandom_range(2, 0)), int'($urandom_range(3, 0)),
                    int'($urandom_range(7, 0)));
      if ($urandom_range(1, 0) == 1) begin
        core_access(a, 1'b1, {$urandom, $urandom}, 8'($urandom_range(255, 0)),
                    int'($urandom_range(2, 0)));
      end else begin
        core_access(a, 1'b0, '0, '0, int'($urandom_range(2, 0)));
      end
    end

    n = 0;
    while (done_q.size() > 0 && n < DROP_TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (done_q.size() == 0 && n_checked == n_issued) begin
      $display("%0d accesses checked", n_checked);
      $display("PASS: all tests");
      $finish;
    end else begin
      $display("compare process stalled: %0d of %0d accesses checked", n_checked, n_issued);
      abort_run();
    end
  end

endmodule

//--- vlog.f
logic/dcache_pkg.sv
logic/sram_1p_bw.sv
logic/dcache_data.sv
logic/dcache_tag.sv
logic/dcache_ctrl.sv
logic/dcache_top.sv
testbench/dcache_mem_model.sv
testbench/dcache_tb.sv

//--- run.sh
#!/bin/sh
# build the dcache testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert \
  --top-module dcache_tb \
  --Mdir "$OBJ_DIR" -o dcache_sim \
  -f vlog.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$OBJ_DIR/dcache_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulator exited with status $status"
fi

if grep -qx "PASS: all tests" "$LOG"; then
  echo "simulation passed"
  exit 0
fi
echo "simulation failed, see $LOG"
exit 1
